/* logic/ecc_mem_pkg.sv */
`default_nettype none

package ecc_mem_pkg;

    localparam int DATA_W = 80;
    localparam int PAR_W  = 8;
    localparam int CODE_W = DATA_W + PAR_W;
    localparam int ADDR_W = 6;
    localparam int DEPTH  = 1 << ADDR_W;
    localparam int POS_W  = 7;            // Enough to name any codeword bit
    localparam int CNT_W  = 16;

    localparam logic [1:0] REG_CTRL = 2'd0;
    localparam logic [1:0] REG_INJ  = 2'd1;
    localparam logic [1:0] REG_SCNT = 2'd2;
    localparam logic [1:0] REG_DCNT = 2'd3;

    typedef struct packed {
        logic [PAR_W-1:0]  parity;        // Bits 87..80
        logic [DATA_W-1:0] data;
    } code_fields_t;

    typedef union packed {
        logic [CODE_W-1:0] flat;
        code_fields_t      f;
    } code_word_u;

    // H matrix column of each data bit, all of odd weight
    localparam logic [PAR_W-1:0] ECC_COL [DATA_W] = '{
        8'h83, 8'h85, 8'h86, 8'h07, 8'h89, 8'h8A, 8'h0B, 8'h8C, 8'h0D, 8'h0E,
        8'h8F, 8'h91, 8'h92, 8'h13, 8'h94, 8'h15, 8'h16, 8'h97, 8'h98, 8'h19,
        8'h1A, 8'h9B, 8'h1C, 8'h9D, 8'h9E, 8'h1F, 8'hA1, 8'hA2, 8'h23, 8'hA4,
        8'h25, 8'h26, 8'hA7, 8'hA8, 8'h29, 8'h2A, 8'hAB, 8'h2C, 8'hAD, 8'hAE,
        8'h2F, 8'hB0, 8'h31, 8'h32, 8'hB3, 8'h34, 8'hB5, 8'hB6, 8'h37, 8'h38,
        8'hB9, 8'hBA, 8'h3B, 8'hBC, 8'h3D, 8'h3E, 8'hBF, 8'hC1, 8'hC2, 8'h43,
        8'hC4, 8'h45, 8'h46, 8'hC7, 8'hC8, 8'h49, 8'h4A, 8'hCB, 8'h4C, 8'hCD,
        8'hCE, 8'h4F, 8'hD0, 8'h51, 8'h52, 8'hD3, 8'h54, 8'hD5, 8'hD6, 8'h57
    };

    function automatic logic [PAR_W-1:0] ecc_encode(input logic [DATA_W-1:0] d);
        logic [PAR_W-1:0] p;
        p = '0;
        for (int i = 0; i < DATA_W; i++) begin
            if (d[i]) begin
                p = p ^ ECC_COL[i];
            end
        end
        return p;
    endfunction

endpackage

`default_nettype wire

/* logic/ecc_80_cal.sv */
`default_nettype none
`timescale 1ns/1ns

module ecc_80_cal
    import ecc_mem_pkg::*;
(
    input  wire [DATA_W-1:0]  data_in,
    input  wire [PAR_W-1:0]   parity_in,
    input  wire               bypass,
    output logic [DATA_W-1:0] data_out,
    output logic              sbit_err,
    output logic              dbit_err
);

    logic [PAR_W-1:0]  syndrome;
    logic [POS_W-1:0]  err_pos;     // Codeword bit to flip, all ones if none
    logic [1:0]        error;       // [0] single, [1] double
    logic [DATA_W-1:0] mask;

    assign syndrome = parity_in ^ ecc_encode(data_in);

    always_comb begin
        err_pos = '1;
        error   = 2'b01;
        case (syndrome)
            8'h00: error = 2'b00;
            8'h83: err_pos = 7'd0;
            8'h85: err_pos = 7'd1;
            8'h86: err_pos = 7'd2;
            8'h07: err_pos = 7'd3;
            8'h89: err_pos = 7'd4;
            8'h8A: err_pos = 7'd5;
            8'h0B: err_pos = 7'd6;
            8'h8C: err_pos = 7'd7;
            8'h0D: err_pos = 7'd8;
            8'h0E: err_pos = 7'd9;
            8'h8F: err_pos = 7'd10;
            8'h91: err_pos = 7'd11;
            8'h92: err_pos = 7'd12;
            8'h13: err_pos = 7'd13;
            8'h94: err_pos = 7'd14;
            8'h15: err_pos = 7'd15;
            8'h16: err_pos = 7'd16;
            8'h97: err_pos = 7'd17;
            8'h98: err_pos = 7'd18;
            8'h19: err_pos = 7'd19;
            8'h1A: err_pos = 7'd20;
            8'h9B: err_pos = 7'd21;
            8'h1C: err_pos = 7'd22;
            8'h9D: err_pos = 7'd23;
            8'h9E: err_pos = 7'd24;
            8'h1F: err_pos = 7'd25;
            8'hA1: err_pos = 7'd26;
            8'hA2: err_pos = 7'd27;
            8'h23: err_pos = 7'd28;
            8'hA4: err_pos = 7'd29;
            8'h25: err_pos = 7'd30;
            8'h26: err_pos = 7'd31;
            8'hA7: err_pos = 7'd32;
            8'hA8: err_pos = 7'd33;
            8'h29: err_pos = 7'd34;
            8'h2A: err_pos = 7'd35;
            8'hAB: err_pos = 7'd36;
            8'h2C: err_pos = 7'd37;
            8'hAD: err_pos = 7'd38;
            8'hAE: err_pos = 7'd39;
            8'h2F: err_pos = 7'd40;
            8'hB0: err_pos = 7'd41;
            8'h31: err_pos = 7'd42;
            8'h32: err_pos = 7'd43;
            8'hB3: err_pos = 7'd44;
            8'h34: err_pos = 7'd45;
            8'hB5: err_pos = 7'd46;
            8'hB6: err_pos = 7'd47;
            8'h37: err_pos = 7'd48;
            8'h38: err_pos = 7'd49;
            8'hB9: err_pos = 7'd50;
            8'hBA: err_pos = 7'd51;
            8'h3B: err_pos = 7'd52;
            8'hBC: err_pos = 7'd53;
            8'h3D: err_pos = 7'd54;
            8'h3E: err_pos = 7'd55;
            8'hBF: err_pos = 7'd56;
            8'hC1: err_pos = 7'd57;
            8'hC2: err_pos = 7'd58;
            8'h43: err_pos = 7'd59;
            8'hC4: err_pos = 7'd60;
            8'h45: err_pos = 7'd61;
            8'h46: err_pos = 7'd62;
            8'hC7: err_pos = 7'd63;
            8'hC8: err_pos = 7'd64;
            8'h49: err_pos = 7'd65;
            8'h4A: err_pos = 7'd66;
            8'hCB: err_pos = 7'd67;
            8'h4C: err_pos = 7'd68;
            8'hCD: err_pos = 7'd69;
            8'hCE: err_pos = 7'd70;
            8'h4F: err_pos = 7'd71;
            8'hD0: err_pos = 7'd72;
            8'h51: err_pos = 7'd73;
            8'h52: err_pos = 7'd74;
            8'hD3: err_pos = 7'd75;
            8'h54: err_pos = 7'd76;
            8'hD5: err_pos = 7'd77;
            8'hD6: err_pos = 7'd78;
            8'h57: err_pos = 7'd79;
            // Check bit itself flipped, data is intact
            8'h01: err_pos = 7'd80;
            8'h02: err_pos = 7'd81;
            8'h04: err_pos = 7'd82;
            8'h08: err_pos = 7'd83;
            8'h10: err_pos = 7'd84;
            8'h20: err_pos = 7'd85;
            8'h40: err_pos = 7'd86;
            8'h80: err_pos = 7'd87;
            default: error = 2'b10;       // Even weight, not correctable
        endcase
    end

    // One-hot, empty for parity positions
    assign mask = (err_pos < POS_W'(DATA_W)) ? (DATA_W'(1) << err_pos) : '0;

    assign data_out = bypass ? data_in : data_in ^ mask;
    assign sbit_err = !bypass && error[0];
    assign dbit_err = !bypass && error[1];

endmodule

`default_nettype wire

/* logic/ecc_mem_array.sv */
`default_nettype none
`timescale 1ns/1ns

module ecc_mem_array
    import ecc_mem_pkg::*;
(
    input  wire              clk,
    input  wire              arst_n,
    input  wire              mem_we,
    input  wire              mem_re,
    input  wire [ADDR_W-1:0] mem_addr,
    input  wire [DATA_W-1:0] mem_wdata,
    input  wire              inj_a_en,
    input  wire [POS_W-1:0]  inj_a_pos,
    input  wire              inj_b_en,
    input  wire [POS_W-1:0]  inj_b_pos,
    output code_word_u       rd_code,
    output logic             rd_valid
);

    code_word_u        mem [DEPTH];
    code_word_u        wr_code;
    logic [CODE_W-1:0] flip_a;
    logic [CODE_W-1:0] flip_b;

    // Shifting past bit 87 leaves the mask empty
    assign flip_a = {{(CODE_W-1){1'b0}}, inj_a_en} << inj_a_pos;
    assign flip_b = {{(CODE_W-1){1'b0}}, inj_b_en} << inj_b_pos;

    always_comb begin
        wr_code.f.data   = mem_wdata;
        wr_code.f.parity = ecc_encode(mem_wdata);
        wr_code.flat     = wr_code.flat ^ flip_a ^ flip_b;
    end

    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[mem_addr] <= wr_code;
        end
        if (mem_re) begin
            rd_code <= mem[mem_addr];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= mem_re;       // One pulse per read, no hold
        end
    end

endmodule

`default_nettype wire

/* logic/ecc_mem_regs.sv */
`default_nettype none
`timescale 1ns/1ns

module ecc_mem_regs
    import ecc_mem_pkg::*;
(
    input  wire              clk,
    input  wire              arst_n,
    input  wire              cfg_we,
    input  wire  [1:0]       cfg_addr,
    input  wire  [15:0]      cfg_wdata,
    output logic [15:0]      cfg_rdata,
    input  wire              rd_valid,
    input  wire              sbit_err,
    input  wire              dbit_err,
    output logic             bypass,
    output logic             inj_a_en,
    output logic [POS_W-1:0] inj_a_pos,
    output logic             inj_b_en,
    output logic [POS_W-1:0] inj_b_pos
);

    logic [CNT_W-1:0] cnt [2];        // [0] corrected, [1] uncorrectable
    logic [1:0]       cnt_hit;
    logic [1:0]       cnt_clr;

    assign cnt_hit = {dbit_err, sbit_err} & {2{rd_valid}};
    assign cnt_clr = {cfg_we && cfg_addr == REG_DCNT, cfg_we && cfg_addr == REG_SCNT};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bypass    <= 1'b0;
            inj_a_en  <= 1'b0;
            inj_b_en  <= 1'b0;
            inj_a_pos <= '0;
            inj_b_pos <= '0;
        end else if (cfg_we) begin
            if (cfg_addr == REG_CTRL) begin
                bypass   <= cfg_wdata[0];
                inj_a_en <= cfg_wdata[1];
                inj_b_en <= cfg_wdata[2];
            end
            if (cfg_addr == REG_INJ) begin
                inj_a_pos <= cfg_wdata[6:0];
                inj_b_pos <= cfg_wdata[14:8];
            end
        end
    end

    for (genvar i = 0; i < 2; i++) begin : g_cnt
        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                cnt[i] <= '0;
            end else if (cnt_clr[i]) begin
                cnt[i] <= '0;
            end else if (cnt_hit[i] && cnt[i] != '1) begin
                cnt[i] <= cnt[i] + 1'b1;    // Sticks at all ones
            end
        end
    end

    always_comb begin
        case (cfg_addr)
            REG_CTRL: cfg_rdata = {13'd0, inj_b_en, inj_a_en, bypass};
            REG_INJ:  cfg_rdata = {1'b0, inj_b_pos, 1'b0, inj_a_pos};
            REG_SCNT: cfg_rdata = cnt[0];
            REG_DCNT: cfg_rdata = cnt[1];
            default:  cfg_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

/* logic/ecc_mem_top.sv */
`default_nettype none
`timescale 1ns/1ns

module ecc_mem_top
    import ecc_mem_pkg::*;
(
    input  wire              clk,
    input  wire              arst_n,
    input  wire              mem_we,
    input  wire              mem_re,
    input  wire [ADDR_W-1:0] mem_addr,
    input  wire [DATA_W-1:0] mem_wdata,
    output wire              rd_valid,
    output wire [DATA_W-1:0] rd_data,
    output wire              sbit_err,
    output wire              dbit_err,
    input  wire              cfg_we,
    input  wire [1:0]        cfg_addr,
    input  wire [15:0]       cfg_wdata,
    output wire [15:0]       cfg_rdata
);

    code_word_u       rd_code;
    wire              bypass;
    wire              inj_a_en;
    wire              inj_b_en;
    wire [POS_W-1:0]  inj_a_pos;
    wire [POS_W-1:0]  inj_b_pos;

    ecc_mem_array u_array (
        .clk       (clk),
        .arst_n    (arst_n),
        .mem_we    (mem_we),
        .mem_re    (mem_re),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .inj_a_en  (inj_a_en),
        .inj_a_pos (inj_a_pos),
        .inj_b_en  (inj_b_en),
        .inj_b_pos (inj_b_pos),
        .rd_code   (rd_code),
        .rd_valid  (rd_valid)
    );

    // Decode straight off the read register
    ecc_80_cal u_dec (
        .data_in   (rd_code.f.data),
        .parity_in (rd_code.f.parity),
        .bypass    (bypass),
        .data_out  (rd_data),
        .sbit_err  (sbit_err),
        .dbit_err  (dbit_err)
    );

    ecc_mem_regs u_regs (
        .clk       (clk),
        .arst_n    (arst_n),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .rd_valid  (rd_valid),
        .sbit_err  (sbit_err),
        .dbit_err  (dbit_err),
        .bypass    (bypass),
        .inj_a_en  (inj_a_en),
        .inj_a_pos (inj_a_pos),
        .inj_b_en  (inj_b_en),
        .inj_b_pos (inj_b_pos)
    );

endmodule

`default_nettype wire

/* testbench/tb_ecc_util.svh */
`ifndef TB_ECC_UTIL_SVH
`define TB_ECC_UTIL_SVH

logic [15:0]       lfsr_state = 16'd80;
logic [DATA_W-1:0] shadow [DEPTH];      // Clean data as last written

// Taps 16, 14, 13, 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

function automatic logic [DATA_W-1:0] take_bits(input int n);
    logic [DATA_W-1:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        v[i] = lfsr_state[0];
    end
    return v;
endfunction

task automatic cfg_write(input logic [1:0] addr, input logic [15:0] data);
    @(negedge clk);
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    @(negedge clk);
    cfg_we    = 1'b0;
endtask

task automatic cfg_read(input logic [1:0] addr, output logic [15:0] data);
    @(negedge clk);
    cfg_addr = addr;
    @(negedge clk);
    data = cfg_rdata;                   // Settled for half a cycle
endtask

`endif

/* testbench/tb_ecc_mem.sv */
`default_nettype none
`timescale 1ns/1ns

module tb_ecc_mem
    import ecc_mem_pkg::*;
;

    logic              clk;
    logic              arst_n;
    logic              mem_we;
    logic              mem_re;
    logic [ADDR_W-1:0] mem_addr;
    logic [DATA_W-1:0] mem_wdata;
    logic              rd_valid;
    logic [DATA_W-1:0] rd_data;
    logic              sbit_err;
    logic              dbit_err;
    logic              cfg_we;
    logic [1:0]        cfg_addr;
    logic [15:0]       cfg_wdata;
    logic [15:0]       cfg_rdata;

    `include "tb_ecc_util.svh"

    ecc_mem_top UUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .mem_we    (mem_we),
        .mem_re    (mem_re),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data),
        .sbit_err  (sbit_err),
        .dbit_err  (dbit_err),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_equal(input string name, input logic [DATA_W-1:0] expected,
                               input logic [DATA_W-1:0] actual);
        assert (actual === expected) else begin
            $display("ERR %s: expected %h, actual %h", name, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
    endtask

    task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        @(negedge clk);
        mem_we    = 1'b1;
        mem_addr  = addr;
        mem_wdata = data;
        @(negedge clk);
        mem_we    = 1'b0;
        shadow[addr] = data;
    endtask

    // Single read, waits for the valid pulse
    task automatic read_word(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                             output logic s, output logic d);
        int waited;
        @(negedge clk);
        mem_re   = 1'b1;
        mem_addr = addr;
        @(negedge clk);
        mem_re   = 1'b0;
        waited   = 1;
        while (!rd_valid && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        if (!rd_valid) begin
            $display("Timed out waiting for rd_valid after a read of address %0d", addr);
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
        check_equal("read latency", 1, waited);
        data = rd_data;
        s    = sbit_err;
        d    = dbit_err;
    endtask

    initial begin
        logic [DATA_W-1:0] got_data;
        logic [DATA_W-1:0] flipped;
        logic              got_s;
        logic              got_d;
        logic [15:0]       reg_val;
        int                pos_a;
        int                pos_b;
        int                s_expect;
        int                d_expect;

        arst_n    = 1'b0;
        mem_we    = 1'b0;
        mem_re    = 1'b0;
        mem_addr  = '0;
        mem_wdata = '0;
        cfg_we    = 1'b0;
        cfg_addr  = '0;
        cfg_wdata = '0;
        s_expect  = 0;
        d_expect  = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        cfg_read(REG_CTRL, reg_val);
        check_equal("ctrl after reset", 0, reg_val);

        // Clean words, then a back-to-back read burst
        for (int i = 0; i < 16; i++) begin
            write_word(ADDR_W'(i * 4), take_bits(DATA_W));
        end
        for (int i = 0; i <= 16; i++) begin
            @(negedge clk);
            if (i > 0) begin
                check_equal("clean valid", 1, rd_valid);
                check_equal("clean data", shadow[(i - 1) * 4], rd_data);
                check_equal("clean sbit", 0, sbit_err);
                check_equal("clean dbit", 0, dbit_err);
            end
            mem_re   = (i < 16);
            mem_addr = ADDR_W'(i * 4);
        end
        @(negedge clk);
        check_equal("valid after burst", 0, rd_valid);

        // Single flips, first few land on check bits
        cfg_write(REG_CTRL, 16'h0002);
        for (int i = 0; i < 24; i++) begin
            pos_a = (i < 4) ? 80 + int'(take_bits(3)) : int'(take_bits(7) % 88);
            cfg_write(REG_INJ, {9'd0, 7'(pos_a)});
            write_word(ADDR_W'(i + 1), take_bits(DATA_W));
            read_word(ADDR_W'(i + 1), got_data, got_s, got_d);
            check_equal($sformatf("single data pos %0d", pos_a), shadow[i + 1], got_data);
            check_equal($sformatf("single sbit pos %0d", pos_a), 1, got_s);
            check_equal($sformatf("single dbit pos %0d", pos_a), 0, got_d);
            s_expect++;
        end

        cfg_write(REG_CTRL, 16'h0006);
        for (int i = 0; i < 8; i++) begin
            pos_a = int'(take_bits(7) % 88);
            pos_b = (pos_a + 1 + int'(take_bits(7) % 87)) % 88;     // Never equal to pos_a
            cfg_write(REG_INJ, {1'b0, 7'(pos_b), 1'b0, 7'(pos_a)});
            cfg_read(REG_INJ, reg_val);
            check_equal("inj readback", {1'b0, 7'(pos_b), 1'b0, 7'(pos_a)}, reg_val);
            write_word(ADDR_W'(i + 32), take_bits(DATA_W));
            read_word(ADDR_W'(i + 32), got_data, got_s, got_d);
            check_equal($sformatf("double dbit %0d/%0d", pos_a, pos_b), 1, got_d);
            check_equal($sformatf("double sbit %0d/%0d", pos_a, pos_b), 0, got_s);
            d_expect++;
        end

        // Raw data passes through with the flipped bit still in it
        for (int i = 0; i < 4; i++) begin
            pos_a = int'(take_bits(7) % 80);
            cfg_write(REG_CTRL, 16'h0002);
            cfg_write(REG_INJ, {9'd0, 7'(pos_a)});
            write_word(ADDR_W'(i + 48), take_bits(DATA_W));
            cfg_write(REG_CTRL, 16'h0001);
            read_word(ADDR_W'(i + 48), got_data, got_s, got_d);
            flipped = shadow[i + 48];
            flipped[pos_a] = ~flipped[pos_a];
            check_equal($sformatf("bypass data pos %0d", pos_a), flipped, got_data);
            check_equal("bypass sbit", 0, got_s);
            check_equal("bypass dbit", 0, got_d);
        end
        cfg_write(REG_CTRL, 16'h0000);

        cfg_read(REG_SCNT, reg_val);
        check_equal("single count", s_expect, reg_val);
        cfg_read(REG_DCNT, reg_val);
        check_equal("double count", d_expect, reg_val);
        cfg_write(REG_SCNT, 16'hFFFF);
        cfg_read(REG_SCNT, reg_val);
        check_equal("single count cleared", 0, reg_val);
        cfg_write(REG_DCNT, 16'hFFFF);
        cfg_read(REG_DCNT, reg_val);
        check_equal("double count cleared", 0, reg_val);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+testbench
logic/ecc_mem_pkg.sv
logic/ecc_80_cal.sv
logic/ecc_mem_array.sv
logic/ecc_mem_regs.sv
logic/ecc_mem_top.sv
testbench/tb_ecc_mem.sv

/* run_sim.sh */
#!/bin/sh
# Run from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_ecc_mem \
    -f build.f -o tb_ecc_mem &&
./obj_dir/tb_ecc_mem | tee /dev/stderr | grep -q "ALL TESTS PASSED" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
